// File: common/glay_pkg.sv
// -------------------------------------------------------------------------
// shared widths and types for the single compute unit
// word addressed memory, one vertex degree per data word
// the vertex sum wraps modulo 2**data_w, no overflow flag
// -------------------------------------------------------------------------

`default_nettype none

package glay_pkg;

  // -------------------------------------------------------------------------
  // widths
  // -------------------------------------------------------------------------
  // word address into vertex memory
  localparam int addr_w  = 16;
  // vertex degree word and sum
  localparam int data_w  = 32;
  // vertex count field of the descriptor
  localparam int count_w = 16;

  // -------------------------------------------------------------------------
  // types
  // -------------------------------------------------------------------------
  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [data_w-1:0]  data_t;
  typedef logic [count_w-1:0] count_t;

  // control chain states
  // done_hold keeps done up until continue
  typedef enum logic [1:0] {
    idle      = 2'd0,
    run       = 2'd1,
    done_hold = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: control/glay_kernel_control.sv
// -------------------------------------------------------------------------
// control chain FSM: idle, run, done_hold
// descriptor taken only while idle; count clamped to max_vertices
// each descriptor launches one run, then a new one is needed
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_kernel_control #(
  parameter int max_vertices = 1024
) (
  input  logic             ap_clk,
  input  logic             rst,
  input  logic             start,
  input  logic             ap_continue,
  output logic             ready,
  output logic             done,
  output logic             idle,
  input  logic             desc_valid,
  input  glay_pkg::addr_t  desc_base,
  input  glay_pkg::count_t desc_count,
  input  glay_pkg::addr_t  desc_result,
  output logic             run_start,
  output glay_pkg::addr_t  run_base,
  output glay_pkg::count_t run_count,
  output glay_pkg::addr_t  run_result,
  input  logic             run_finish
);

  localparam glay_pkg::count_t max_count = glay_pkg::count_t'(max_vertices);

  glay_pkg::ctrl_state_t state;
  logic desc_loaded;
  logic launch;
  logic go;
  logic capture;

  // start is a level, taken once a descriptor is held
  assign go      = (state == glay_pkg::idle) && start && desc_loaded;
  assign capture = desc_valid && (state == glay_pkg::idle) && !go;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state       <= glay_pkg::idle;
      desc_loaded <= 1'b0;
      launch      <= 1'b0;
    end else begin
      launch <= go;
      case (state)
        glay_pkg::idle:      if (go) state <= glay_pkg::run;
        glay_pkg::run:       if (run_finish) state <= glay_pkg::done_hold;
        glay_pkg::done_hold: if (ap_continue) state <= glay_pkg::idle;
        default:             state <= glay_pkg::idle;
      endcase
      // descriptor consumed by the launch
      if (go) begin
        desc_loaded <= 1'b0;
      end else if (capture) begin
        desc_loaded <= 1'b1;
      end
    end
  end

  // descriptor fields
  always_ff @(posedge ap_clk) begin
    if (capture) begin
      run_base   <= desc_base;
      run_count  <= (desc_count > max_count) ? max_count : desc_count;
      run_result <= desc_result;
    end
  end

  // ready and run_start are the same one-cycle pulse
  assign ready     = launch;
  assign run_start = launch;
  assign done      = (state == glay_pkg::done_hold);
  assign idle      = (state == glay_pkg::idle);

  assert property (@(posedge ap_clk) disable iff (rst) run_finish |-> state == glay_pkg::run)
    else $error("run_finish outside run");

endmodule

`default_nettype wire

// File: engine/glay_vertex_reader.sv
// -------------------------------------------------------------------------
// sums run_count words from run_base upward, writes sum to run_result
// one read outstanding; next request the cycle after its valid
// run_count must already be clamped to max_vertices
// no timeout, a stalled memory stalls the engine
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_vertex_reader #(
  parameter int max_vertices = 1024
) (
  input  logic             ap_clk,
  input  logic             rst,
  input  logic             run_start,
  input  glay_pkg::addr_t  run_base,
  input  glay_pkg::count_t run_count,
  input  glay_pkg::addr_t  run_result,
  output logic             run_finish,
  output logic             mem_rd_req,
  output glay_pkg::addr_t  mem_rd_addr,
  input  logic             mem_rd_valid,
  input  glay_pkg::data_t  mem_rd_data,
  output logic             mem_wr_req,
  output glay_pkg::addr_t  mem_wr_addr,
  output glay_pkg::data_t  mem_wr_data,
  input  logic             mem_wr_ack
);

  // remaining count, just wide enough for max_vertices
  localparam int left_w = $clog2(max_vertices + 1);

  localparam logic [1:0] s_idle  = 2'd0;
  localparam logic [1:0] s_read  = 2'd1;
  localparam logic [1:0] s_write = 2'd2;

  logic [1:0]        state;
  logic [left_w-1:0] left;
  glay_pkg::addr_t   addr;
  glay_pkg::addr_t   result;
  glay_pkg::data_t   sum;

  // -------------------------------------------------------------------------
  // sequencer
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state      <= s_idle;
      mem_rd_req <= 1'b0;
      mem_wr_req <= 1'b0;
      run_finish <= 1'b0;
    end else begin
      // request and finish are single-cycle pulses
      mem_rd_req <= 1'b0;
      mem_wr_req <= 1'b0;
      run_finish <= 1'b0;
      case (state)
        s_idle: begin
          if (run_start) begin
            // empty vertex list goes straight to the write
            if (run_count == '0) begin
              state      <= s_write;
              mem_wr_req <= 1'b1;
            end else begin
              state      <= s_read;
              mem_rd_req <= 1'b1;
            end
          end
        end
        s_read: begin
          if (mem_rd_valid) begin
            if (left == left_w'(1)) begin
              state      <= s_write;
              mem_wr_req <= 1'b1;
            end else begin
              mem_rd_req <= 1'b1;
            end
          end
        end
        s_write: begin
          if (mem_wr_ack) begin
            state      <= s_idle;
            run_finish <= 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // datapath
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (state == s_idle && run_start) begin
      addr   <= run_base;
      left   <= left_w'(run_count);
      result <= run_result;
      sum    <= '0;
    end else if (state == s_read && mem_rd_valid) begin
      // wraps at data_w
      addr <= addr + 1'b1;
      left <= left - 1'b1;
      sum  <= sum + mem_rd_data;
    end
  end

  assign mem_rd_addr = addr;
  assign mem_wr_addr = result;
  // sum is final by the cycle mem_wr_req rises
  assign mem_wr_data = sum;

  assert property (@(posedge ap_clk) disable iff (rst) mem_rd_valid |-> state == s_read)
    else $error("read data without an outstanding read");

endmodule

`default_nettype wire

// File: verilog/glay_kernel_cu.sv
// -------------------------------------------------------------------------
// one compute unit, control chain plus a single vertex reader
// every boundary signal has one register stage, in and out
// so each path is 2 cycles longer than the inner blocks
// reset is registered once here; hold it at least 2 cycles
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_kernel_cu #(
  parameter int max_vertices = 1024
) (
  input  logic             ap_clk,
  input  logic             m_axi_areset,
  // control chain
  input  logic             start,
  input  logic             ap_continue,
  output logic             ready,
  output logic             done,
  output logic             idle,
  // descriptor
  input  logic             desc_valid,
  input  glay_pkg::addr_t  desc_base,
  input  glay_pkg::count_t desc_count,
  input  glay_pkg::addr_t  desc_result,
  // memory read port
  output logic             mem_rd_req,
  output glay_pkg::addr_t  mem_rd_addr,
  input  logic             mem_rd_valid,
  input  glay_pkg::data_t  mem_rd_data,
  // memory write port
  output logic             mem_wr_req,
  output glay_pkg::addr_t  mem_wr_addr,
  output glay_pkg::data_t  mem_wr_data,
  input  logic             mem_wr_ack
);

  // -------------------------------------------------------------------------
  // internal signals
  // -------------------------------------------------------------------------
  logic             rst;
  // registered inputs
  logic             start_r;
  logic             cont_r;
  logic             desc_valid_r;
  glay_pkg::addr_t  desc_base_r;
  glay_pkg::count_t desc_count_r;
  glay_pkg::addr_t  desc_result_r;
  logic             rd_valid_r;
  glay_pkg::data_t  rd_data_r;
  logic             wr_ack_r;
  // block outputs, before the output stage
  logic             ctrl_ready;
  logic             ctrl_done;
  logic             ctrl_idle;
  logic             rd_req;
  glay_pkg::addr_t  rd_addr;
  logic             wr_req;
  glay_pkg::addr_t  wr_addr;
  glay_pkg::data_t  wr_data;
  // control to reader
  logic             run_start;
  glay_pkg::addr_t  run_base;
  glay_pkg::count_t run_count;
  glay_pkg::addr_t  run_result;
  logic             run_finish;

  // local reset copy
  always_ff @(posedge ap_clk) begin
    rst <= m_axi_areset;
  end

  // -------------------------------------------------------------------------
  // input stage
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      start_r      <= 1'b0;
      cont_r       <= 1'b0;
      desc_valid_r <= 1'b0;
      rd_valid_r   <= 1'b0;
      wr_ack_r     <= 1'b0;
    end else begin
      start_r      <= start;
      cont_r       <= ap_continue;
      desc_valid_r <= desc_valid;
      rd_valid_r   <= mem_rd_valid;
      wr_ack_r     <= mem_wr_ack;
    end
  end

  // payload, qualified by the strobes above
  always_ff @(posedge ap_clk) begin
    desc_base_r   <= desc_base;
    desc_count_r  <= desc_count;
    desc_result_r <= desc_result;
    rd_data_r     <= mem_rd_data;
  end

  // -------------------------------------------------------------------------
  // output stage
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      ready      <= 1'b0;
      done       <= 1'b0;
      idle       <= 1'b1;
      mem_rd_req <= 1'b0;
      mem_wr_req <= 1'b0;
    end else begin
      ready      <= ctrl_ready;
      done       <= ctrl_done;
      idle       <= ctrl_idle;
      mem_rd_req <= rd_req;
      mem_wr_req <= wr_req;
    end
  end

  always_ff @(posedge ap_clk) begin
    mem_rd_addr <= rd_addr;
    mem_wr_addr <= wr_addr;
    mem_wr_data <= wr_data;
  end

  // -------------------------------------------------------------------------
  // blocks
  // -------------------------------------------------------------------------
  glay_kernel_control #(
    .max_vertices(max_vertices)
  ) u_glay_kernel_control (
    .ap_clk     (ap_clk       ),
    .rst        (rst          ),
    .start      (start_r      ),
    .ap_continue(cont_r       ),
    .ready      (ctrl_ready   ),
    .done       (ctrl_done    ),
    .idle       (ctrl_idle    ),
    .desc_valid (desc_valid_r ),
    .desc_base  (desc_base_r  ),
    .desc_count (desc_count_r ),
    .desc_result(desc_result_r),
    .run_start  (run_start    ),
    .run_base   (run_base     ),
    .run_count  (run_count    ),
    .run_result (run_result   ),
    .run_finish (run_finish   )
  );

  glay_vertex_reader #(
    .max_vertices(max_vertices)
  ) u_glay_vertex_reader (
    .ap_clk      (ap_clk    ),
    .rst         (rst       ),
    .run_start   (run_start ),
    .run_base    (run_base  ),
    .run_count   (run_count ),
    .run_result  (run_result),
    .run_finish  (run_finish),
    .mem_rd_req  (rd_req    ),
    .mem_rd_addr (rd_addr   ),
    .mem_rd_valid(rd_valid_r),
    .mem_rd_data (rd_data_r ),
    .mem_wr_req  (wr_req    ),
    .mem_wr_addr (wr_addr   ),
    .mem_wr_data (wr_data   ),
    .mem_wr_ack  (wr_ack_r  )
  );

  // -------------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------------
  // the reader never overlaps its read and write phases
  assert property (@(posedge ap_clk) disable iff (rst) !(mem_rd_req && mem_wr_req))
    else $error("read and write requests issued together");

  // memory traffic only while the control FSM runs and idle is low
  assert property (@(posedge ap_clk) disable iff (rst)
    (mem_rd_req || mem_wr_req) |->
      !idle && u_glay_kernel_control.state == glay_pkg::run)
    else $error("memory request while idle or outside the run state");

endmodule

`default_nettype wire

// File: tb/glay_clock_gen.sv
// -------------------------------------------------------------------------
// testbench clock and reset, 100 ns period
// reset high from time zero, released after the second rising edge
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_clock_gen (
  output logic ap_clk,
  output logic m_axi_areset
);

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  // two cycles of reset
  initial begin
    m_axi_areset = 1'b1;
    repeat (2) @(posedge ap_clk);
    m_axi_areset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/glay_mem_model.sv
// -------------------------------------------------------------------------
// single-word memory for the testbench, one request outstanding
// answers reads and writes after 1 to 5 cycles, delay from an xorshift
// writes are recorded but not stored; preload through the load port
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_mem_model #(
  parameter logic [31:0] seed = 32'hf828_40ab
) (
  input  logic            ap_clk,
  input  logic            rst,
  input  logic            rd_req,
  input  glay_pkg::addr_t rd_addr,
  output logic            rd_valid,
  output glay_pkg::data_t rd_data,
  input  logic            wr_req,
  input  glay_pkg::addr_t wr_addr,
  input  glay_pkg::data_t wr_data,
  output logic            wr_ack,
  input  logic            load_en,
  input  glay_pkg::addr_t load_addr,
  input  glay_pkg::data_t load_data,
  output glay_pkg::addr_t last_wr_addr,
  output glay_pkg::data_t last_wr_data,
  output int              rd_total,
  output int              wr_total,
  output int              proto_errors
);

  glay_pkg::data_t mem [0:(1 << glay_pkg::addr_w)-1];
  logic [31:0]     rnd;
  logic            busy;
  logic            is_wr;
  glay_pkg::addr_t req_addr;
  glay_pkg::data_t req_data;
  logic [2:0]      wait_cnt;

  function automatic logic [31:0] rng_step(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // preload, only while the DUT is idle
  always @(posedge ap_clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  always @(posedge ap_clk) begin
    rd_valid <= 1'b0;
    wr_ack   <= 1'b0;
    if (rst) begin
      rnd          <= seed;
      busy         <= 1'b0;
      rd_total     <= 0;
      wr_total     <= 0;
      proto_errors <= 0;
    end else if (rd_req || wr_req) begin
      // overlapping or simultaneous requests break the port protocol
      if (busy || (rd_req && wr_req)) begin
        $display("memory model at %0t: new request while one is outstanding", $time);
        proto_errors <= proto_errors + 1;
      end
      busy     <= 1'b1;
      is_wr    <= wr_req;
      req_addr <= wr_req ? wr_addr : rd_addr;
      req_data <= wr_data;
      wait_cnt <= 3'(rnd % 32'd5);
      rnd      <= rng_step(rnd);
    end else if (busy) begin
      if (wait_cnt != 3'd0) begin
        wait_cnt <= wait_cnt - 3'd1;
      end else begin
        busy <= 1'b0;
        if (is_wr) begin
          wr_ack       <= 1'b1;
          last_wr_addr <= req_addr;
          last_wr_data <= req_data;
          wr_total     <= wr_total + 1;
        end else begin
          rd_valid <= 1'b1;
          rd_data  <= mem[req_addr];
          rd_total <= rd_total + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/glay_tb.sv
// -------------------------------------------------------------------------
// testbench top for the compute unit, max_vertices set to 64
// tests come from tb/glay_input.dat, five hex words per line
// fill words pair up to the seed word, so a sum is known per line
// run length limited to 40 cycles per vertex plus 200
// -------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module glay_tb;

  localparam int max_vertices = 64;
  localparam int max_tests    = 32;
  localparam int cols         = 5;

  logic             ap_clk;
  logic             m_axi_areset;
  logic             start;
  logic             ap_continue;
  logic             ready;
  logic             done;
  logic             idle;
  logic             desc_valid;
  glay_pkg::addr_t  desc_base;
  glay_pkg::count_t desc_count;
  glay_pkg::addr_t  desc_result;
  logic             mem_rd_req;
  glay_pkg::addr_t  mem_rd_addr;
  logic             mem_rd_valid;
  glay_pkg::data_t  mem_rd_data;
  logic             mem_wr_req;
  glay_pkg::addr_t  mem_wr_addr;
  glay_pkg::data_t  mem_wr_data;
  logic             mem_wr_ack;
  // memory preload and bookkeeping
  logic             load_en;
  glay_pkg::addr_t  load_addr;
  glay_pkg::data_t  load_data;
  glay_pkg::addr_t  last_wr_addr;
  glay_pkg::data_t  last_wr_data;
  int               rd_total;
  int               wr_total;
  int               proto_errors;

  // base, count, result, seed, expected sum
  glay_pkg::data_t vec [0:max_tests*cols-1];
  int errors      = 0;
  int cycles      = 0;
  int cycle_limit = 32'h7fff_ffff;

  glay_clock_gen u_glay_clock_gen (
    .ap_clk      (ap_clk      ),
    .m_axi_areset(m_axi_areset)
  );

  glay_kernel_cu #(
    .max_vertices(max_vertices)
  ) u_glay_kernel_cu (
    .ap_clk      (ap_clk      ),
    .m_axi_areset(m_axi_areset),
    .start       (start       ),
    .ap_continue (ap_continue ),
    .ready       (ready       ),
    .done        (done        ),
    .idle        (idle        ),
    .desc_valid  (desc_valid  ),
    .desc_base   (desc_base   ),
    .desc_count  (desc_count  ),
    .desc_result (desc_result ),
    .mem_rd_req  (mem_rd_req  ),
    .mem_rd_addr (mem_rd_addr ),
    .mem_rd_valid(mem_rd_valid),
    .mem_rd_data (mem_rd_data ),
    .mem_wr_req  (mem_wr_req  ),
    .mem_wr_addr (mem_wr_addr ),
    .mem_wr_data (mem_wr_data ),
    .mem_wr_ack  (mem_wr_ack  )
  );

  glay_mem_model #(
    .seed(32'hf828_40ab)
  ) u_glay_mem_model (
    .ap_clk      (ap_clk      ),
    .rst         (m_axi_areset),
    .rd_req      (mem_rd_req  ),
    .rd_addr     (mem_rd_addr ),
    .rd_valid    (mem_rd_valid),
    .rd_data     (mem_rd_data ),
    .wr_req      (mem_wr_req  ),
    .wr_addr     (mem_wr_addr ),
    .wr_data     (mem_wr_data ),
    .wr_ack      (mem_wr_ack  ),
    .load_en     (load_en     ),
    .load_addr   (load_addr   ),
    .load_data   (load_data   ),
    .last_wr_addr(last_wr_addr),
    .last_wr_data(last_wr_data),
    .rd_total    (rd_total    ),
    .wr_total    (wr_total    ),
    .proto_errors(proto_errors)
  );

  // -------------------------------------------------------------------------
  // helpers
  // -------------------------------------------------------------------------
  function automatic logic [31:0] rng_step(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic verify_sum(input glay_pkg::data_t got, input glay_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERR %0t: written sum %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input glay_pkg::addr_t got, input glay_pkg::addr_t exp);
    if (got !== exp) begin
      $display("ERR %0t: write address %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic compare_count(input string what, input glay_pkg::count_t got,
                               input glay_pkg::count_t exp);
    if (got !== exp) begin
      $display("ERR %0t: %s %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // even words step the xorshift, odd words complete a pair to the seed
  // an unpaired last word is the seed itself
  task automatic load_vertices(input glay_pkg::addr_t base, input int n,
                               input glay_pkg::data_t seed);
    glay_pkg::data_t r;
    glay_pkg::data_t word;
    int j;
    r = seed;
    for (j = 0; j < n; j++) begin
      if (j[0] == 1'b1) begin
        word = seed - r;
      end else if (j == n - 1) begin
        word = seed;
      end else begin
        r    = rng_step(r);
        word = r;
      end
      @(posedge ap_clk);
      load_en   <= 1'b1;
      load_addr <= glay_pkg::addr_t'(int'(base) + j);
      load_data <= word;
    end
    @(posedge ap_clk);
    load_en <= 1'b0;
  endtask

  task automatic run_test(input int idx);
    glay_pkg::addr_t  base;
    glay_pkg::count_t count;
    glay_pkg::addr_t  result;
    glay_pkg::data_t  seed;
    glay_pkg::data_t  exp_sum;
    int n;
    int rd_before;
    int wr_before;
    int err_before;
    base       = glay_pkg::addr_t'(vec[idx*cols]);
    count      = glay_pkg::count_t'(vec[idx*cols+1]);
    result     = glay_pkg::addr_t'(vec[idx*cols+2]);
    seed       = vec[idx*cols+3];
    exp_sum    = vec[idx*cols+4];
    n          = int'(count);
    err_before = errors;
    load_vertices(base, n, seed);
    rd_before = rd_total;
    wr_before = wr_total;
    // descriptor pulse, then start level until ready
    @(posedge ap_clk);
    desc_valid  <= 1'b1;
    desc_base   <= base;
    desc_count  <= count;
    desc_result <= result;
    @(posedge ap_clk);
    desc_valid <= 1'b0;
    expect_level("idle before start", idle, 1'b1);
    expect_level("done before start", done, 1'b0);
    start <= 1'b1;
    do @(posedge ap_clk); while (!ready);
    start <= 1'b0;
    do @(posedge ap_clk); while (!done);
    verify_sum(last_wr_data, exp_sum);
    check_addr(last_wr_addr, result);
    compare_count("reads", glay_pkg::count_t'(rd_total - rd_before),
                  glay_pkg::count_t'((n > max_vertices) ? max_vertices : n));
    compare_count("writes", glay_pkg::count_t'(wr_total - wr_before), glay_pkg::count_t'(1));
    // done must hold without continue
    repeat (3) begin
      @(posedge ap_clk);
      expect_level("done while waiting for continue", done, 1'b1);
    end
    ap_continue <= 1'b1;
    @(posedge ap_clk);
    ap_continue <= 1'b0;
    do @(posedge ap_clk); while (!idle);
    expect_level("done after continue", done, 1'b0);
    $display("test %0d base %h count %0d result %h sum %h: %s", idx, base, n, result,
             last_wr_data, (errors == err_before) ? "ok" : "FAILED");
  endtask

  // -------------------------------------------------------------------------
  // watchdog
  // -------------------------------------------------------------------------
  always @(posedge ap_clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // main sequence
  // -------------------------------------------------------------------------
  initial begin
    int i;
    int n_tests;
    int total;
    start       <= 1'b0;
    ap_continue <= 1'b0;
    desc_valid  <= 1'b0;
    desc_base   <= '0;
    desc_count  <= '0;
    desc_result <= '0;
    load_en     <= 1'b0;
    load_addr   <= '0;
    load_data   <= '0;
    // all ones marks the lines past the end of the file
    for (i = 0; i < max_tests*cols; i++) begin
      vec[i] = '1;
    end
    $readmemh("tb/glay_input.dat", vec);
    n_tests = 0;
    total   = 0;
    while (n_tests < max_tests && vec[n_tests*cols+1] <= 32'h0000_ffff) begin
      total += int'(vec[n_tests*cols+1]);
      n_tests++;
    end
    cycle_limit = total * 40 + 200;
    if (n_tests == 0) begin
      $display("no tests found in the input file");
      errors++;
    end
    // reset is 2 cycles, plus the local stage and the output stage
    repeat (5) @(posedge ap_clk);
    expect_level("idle after reset", idle, 1'b1);
    expect_level("ready after reset", ready, 1'b0);
    expect_level("done after reset", done, 1'b0);
    for (i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    if (proto_errors != 0) begin
      $display("memory model saw %0d overlapping requests", proto_errors);
      errors += proto_errors;
    end
    $display("tests %0d, errors %0d", n_tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/glay_input.dat
// columns: base  count  result  seed  expected sum, all hex
// words pair up to the seed, so sum = ceil(min(count, 64) / 2) * seed
0100 0003 0800 00000011 00000022
0200 0000 0801 12345678 00000000
0300 0001 0802 deadbeef deadbeef
0400 0002 0803 80000001 80000001
// exactly the limit
1000 0040 0804 9e3779b9 c6ef3720
// above the limit, clamped to 64 words
2000 0046 0805 00000101 00002020
3000 0041 0806 ffffffff ffffffe0
// address wraps past ffff
fff0 0011 0807 01010101 09090909
0500 0005 0808 40000000 c0000000
0600 0020 0809 0badf00d badf00d0
0700 0000 080a 00000000 00000000
4000 00ff 080b 13572468 6ae48d00
0900 0007 080c 00c0ffee 0303ffb8
0a00 0008 080d 55555555 55555554

// File: src.f
common/glay_pkg.sv
control/glay_kernel_control.sv
engine/glay_vertex_reader.sv
verilog/glay_kernel_cu.sv
tb/glay_clock_gen.sv
tb/glay_mem_model.sv
tb/glay_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module glay_tb

# the run passes only if the pass line appears in the output
if ./obj_dir/Vglay_tb | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
